//--- verilog.f
+incdir+common
common/hdmi_pkg.sv
common/tmds_if.sv
src/video_timing.sv
src/period_fsm.sv
tmds_encoder/tmds_encoder.sv
serializer/tmds_serializer.sv
src/hdmi_tx_top.sv
dv/tb_clock_gen.sv
dv/hdmi_tx_assertions.sv
dv/hdmi_tx_tb.sv

//--- Makefile
# Verilator build and run for the HDMI transmit testbench

VERILATOR ?= verilator
TOP       ?= hdmi_tx_tb
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

# Fails unless the pass line appears in the simulation output
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "PASS: all tests"

clean:
	rm -rf $(OBJ_DIR)

//--- dv/hdmi_tx_tb.sv
// HDMI transmit testbench
`include "hdmi_config.svh"

module hdmi_tx_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import hdmi_pkg::*;

    localparam int H_TOTAL   = `HDMI_H_TOTAL;
    localparam int V_TOTAL   = `HDMI_V_TOTAL;
    localparam int FRAME_PIX = H_TOTAL * V_TOTAL;
    localparam int TIMEOUT   = 5000;

    logic        clk_pixel_x5;
    logic        rst_n;
    logic [23:0] rgb;
    logic        pixel_req;
    logic [5:0]  pixel_x;
    logic [2:0]  pixel_y;
    logic [1:0]  tmds_lane0;
    logic [1:0]  tmds_lane1;
    logic [1:0]  tmds_lane2;
    logic [1:0]  tmds_clock_lane;

    logic [23:0] rgb_table [V_TOTAL][H_TOTAL];
    string       test_name [7];
    int          checks [7];
    int          errors [7];
    int          disp [3];
    int          video_count [3];
    int          sync_count;
    logic [9:0]  word [4];
    logic [1:0]  prev_clock;
    logic        started;
    logic        done;
    int          pos;
    int          word_index;
    logic [5:0]  last_x;
    logic [2:0]  last_y;

    tb_clock_gen tb_clock_gen_inst
    (
        .clk_pixel_x5 (clk_pixel_x5),
        .rst_n        (rst_n)
    );

    hdmi_tx_top hdmi_tx_top_inst
    (
        .clk_pixel_x5    (clk_pixel_x5),
        .rst_n           (rst_n),
        .rgb             (rgb),
        .pixel_req       (pixel_req),
        .pixel_x         (pixel_x),
        .pixel_y         (pixel_y),
        .tmds_lane0      (tmds_lane0),
        .tmds_lane1      (tmds_lane1),
        .tmds_lane2      (tmds_lane2),
        .tmds_clock_lane (tmds_clock_lane)
    );

    bind hdmi_tx_top hdmi_tx_assertions hdmi_tx_assertions_inst
    (
        .clk_pixel_x5    (clk_pixel_x5),
        .rst_n           (rst_n),
        .pixel_strobe    (pixel_strobe),
        .pixel_req       (pixel_req),
        .pixel_x         (pixel_x),
        .pixel_y         (pixel_y),
        .tmds_clock_lane (tmds_clock_lane)
    );

    // Raster model, pixel p counted from reset
    function automatic period_t model_period(input int p);
        int h;
        int v;
        logic next_active;
        h = p % H_TOTAL;
        v = (p / H_TOTAL) % V_TOTAL;
        next_active = (v == V_TOTAL - 1) || (v + 1 < `HDMI_V_ACTIVE);
        if ((v < `HDMI_V_ACTIVE) && (h < `HDMI_H_ACTIVE) && (p >= H_TOTAL))
            return VIDEO;
        if (next_active && (h >= H_TOTAL - `HDMI_GUARD_LEN))
            return GUARD;
        if (next_active && (h >= H_TOTAL - `HDMI_GUARD_LEN - `HDMI_PREAMBLE_LEN))
            return PREAMBLE;
        return CONTROL;
    endfunction

    function automatic logic [1:0] model_sync(input int p);
        int h;
        int v;
        logic hs;
        logic vs;
        h = p % H_TOTAL;
        v = (p / H_TOTAL) % V_TOTAL;
        hs = (h >= `HDMI_H_ACTIVE + `HDMI_H_FRONT) &&
             (h < `HDMI_H_ACTIVE + `HDMI_H_FRONT + `HDMI_H_SYNC);
        vs = (v >= `HDMI_V_ACTIVE + `HDMI_V_FRONT) &&
             (v < `HDMI_V_ACTIVE + `HDMI_V_FRONT + `HDMI_V_SYNC);
        return {vs, hs};
    endfunction

    // DVI control characters, c1 c0
    function automatic logic [9:0] control_code(input logic [1:0] c);
        case (c)
            2'b00:   return 10'b1101010100;
            2'b01:   return 10'b0010101011;
            2'b10:   return 10'b0101010100;
            default: return 10'b1010101011;
        endcase
    endfunction

    function automatic logic [9:0] encode_video(input logic [7:0] d, inout int cnt);
        logic [8:0] qm;
        int n1;
        int n0;
        logic invert;
        n1 = $countones(d);
        invert = (n1 > 4) || ((n1 == 4) && !d[0]);
        qm[0] = d[0];
        for (int i = 1; i < 8; i++)
            qm[i] = invert ? (qm[i-1] ~^ d[i]) : (qm[i-1] ^ d[i]);
        qm[8] = !invert;
        n1 = $countones(qm[7:0]);
        n0 = 8 - n1;
        if ((cnt == 0) || (n1 == n0))
        begin
            cnt = qm[8] ? cnt + n1 - n0 : cnt + n0 - n1;
            return {!qm[8], qm[8], qm[8] ? qm[7:0] : ~qm[7:0]};
        end
        if (((cnt > 0) && (n1 > n0)) || ((cnt < 0) && (n0 > n1)))
        begin
            cnt = cnt + (qm[8] ? 2 : 0) + n0 - n1;
            return {1'b1, qm[8], ~qm[7:0]};
        end
        cnt = cnt - (qm[8] ? 0 : 2) + n1 - n0;
        return {1'b0, qm[8], qm[7:0]};
    endfunction

    function automatic logic [9:0] expected_symbol(input int ch, input int p, inout int cnt);
        period_t per;
        logic [1:0] ctrl;
        per = model_period(p);
        if (per == VIDEO)
            return encode_video(rgb_table[(p / H_TOTAL) % V_TOTAL][p % H_TOTAL][8*ch +: 8], cnt);
        cnt = 0;
        if (per == GUARD)
            return (ch == 1) ? 10'b0100110011 : 10'b1011001100;
        ctrl = (ch == 0) ? model_sync(p) : 2'b00;
        if ((ch == 1) && (per == PREAMBLE))
            ctrl = 2'b01;
        return control_code(ctrl);
    endfunction

    task automatic check_word(input int p);
        period_t per;
        logic [9:0] exp_sym;
        int t;
        per = model_period(p);
        t = int'(per) + 1;
        for (int ch = 0; ch < 3; ch++)
        begin
            exp_sym = expected_symbol(ch, p, disp[ch]);
            checks[t]++;
            assert (word[ch] === exp_sym)
            else
            begin
                $display("ERROR %s: pixel %0d ch %0d expected %b actual %b",
                         test_name[t], p, ch, exp_sym, word[ch]);
                errors[t]++;
            end
            if ((p >= FRAME_PIX) && (p < 2 * FRAME_PIX))
            begin
                if ((per != GUARD) && (word[ch] != control_code(2'b00)) &&
                    (word[ch] != control_code(2'b01)) && (word[ch] != control_code(2'b10)) &&
                    (word[ch] != control_code(2'b11)))
                    video_count[ch]++;
                if ((ch == 0) &&
                    ((word[0] == control_code(2'b01)) || (word[0] == control_code(2'b10)) ||
                     (word[0] == control_code(2'b11))))
                    sync_count++;
            end
        end
    endtask

    // Pixel source
    always @(negedge clk_pixel_x5)
    begin
        if (pixel_req)
            rgb <= rgb_table[pixel_y][pixel_x];
    end

    // Raster outputs step once per pixel in raster order
    always @(negedge clk_pixel_x5)
    begin
        logic [5:0] exp_x;
        logic [2:0] exp_y;
        logic       exp_req;
        if (rst_n && (pixel_x != last_x))
        begin
            exp_x = (last_x == 6'(H_TOTAL - 1)) ? 6'd0 : last_x + 6'd1;
            exp_y = last_y;
            if (last_x == 6'(H_TOTAL - 1))
                exp_y = (last_y == 3'(V_TOTAL - 1)) ? 3'd0 : last_y + 3'd1;
            exp_req = (exp_x < `HDMI_H_ACTIVE) && (exp_y < `HDMI_V_ACTIVE);
            checks[6]++;
            assert ({pixel_req, pixel_y, pixel_x} == {exp_req, exp_y, exp_x})
            else
            begin
                $display("ERROR %s: expected req %b y %0d x %0d actual req %b y %0d x %0d",
                         test_name[6], exp_req, exp_y, exp_x, pixel_req, pixel_y, pixel_x);
                errors[6]++;
            end
        end
        last_x = pixel_x;
        last_y = pixel_y;
    end

    // Lane deserializer and compare
    always @(negedge clk_pixel_x5)
    begin
        if (rst_n)
        begin
            if (!started && (tmds_clock_lane == 2'b11) && (prev_clock == 2'b00))
            begin
                started = 1'b1;
                pos = 0;
            end
            else if (!started)
            begin
                checks[0]++;
                assert ({tmds_lane0, tmds_lane1, tmds_lane2, tmds_clock_lane} == 8'h00)
                else
                begin
                    $display("ERROR %s: expected 00 actual %b %b %b %b before first load",
                             test_name[0], tmds_lane0, tmds_lane1, tmds_lane2,
                             tmds_clock_lane);
                    errors[0]++;
                end
            end
            if (started && !done)
            begin
                word[0][2*pos +: 2] = tmds_lane0;
                word[1][2*pos +: 2] = tmds_lane1;
                word[2][2*pos +: 2] = tmds_lane2;
                word[3][2*pos +: 2] = tmds_clock_lane;
                pos++;
                if (pos == 5)
                begin
                    pos = 0;
                    checks[0]++;
                    assert (word[3] == TMDS_CLOCK_PATTERN)
                    else
                    begin
                        $display("ERROR %s: word %0d expected %b actual %b",
                                 test_name[0], word_index, TMDS_CLOCK_PATTERN, word[3]);
                        errors[0]++;
                    end
                    // Two pixels of pipeline fill ahead of pixel 0
                    if (word_index >= 2)
                        check_word(word_index - 2);
                    if (word_index - 2 == 2 * FRAME_PIX - 1)
                        done = 1'b1;
                    word_index++;
                end
            end
        end
        prev_clock = tmds_clock_lane;
    end

    initial
    begin
        int cycles;
        int exp_sync;
        int total;
        rgb = '0;
        started = 1'b0;
        done = 1'b0;
        pos = 0;
        word_index = 0;
        prev_clock = 2'b00;
        sync_count = 0;
        cycles = 0;
        exp_sync = 0;
        total = 0;
        test_name = '{"clock_lane", "blanking", "preamble", "guard", "video", "frame_counts",
                      "raster"};
        for (int i = 0; i < 7; i++)
        begin
            checks[i] = 0;
            errors[i] = 0;
        end
        for (int i = 0; i < 3; i++)
        begin
            disp[i] = 0;
            video_count[i] = 0;
        end
        void'($urandom(20));
        for (int y = 0; y < V_TOTAL; y++)
            for (int x = 0; x < H_TOTAL; x++)
                rgb_table[y][x] = 24'($urandom());

        while (!done && (cycles < TIMEOUT))
        begin
            @(negedge clk_pixel_x5);
            cycles++;
        end

        if (!done)
        begin
            $display("Timeout after %0d cycles before two frames were received", cycles);
            $display("FAIL: see errors above");
            $finish;
        end
        else
        begin
            for (int p = FRAME_PIX; p < 2 * FRAME_PIX; p++)
                if ((model_period(p) != GUARD) && (model_period(p) != VIDEO) &&
                    (model_sync(p) != 2'b00))
                    exp_sync++;
            for (int ch = 0; ch < 3; ch++)
            begin
                checks[5]++;
                assert (video_count[ch] == `HDMI_H_ACTIVE * `HDMI_V_ACTIVE)
                else
                begin
                    $display("ERROR %s: ch %0d video symbols expected %0d actual %0d",
                             test_name[5], ch, `HDMI_H_ACTIVE * `HDMI_V_ACTIVE,
                             video_count[ch]);
                    errors[5]++;
                end
            end
            checks[5]++;
            assert (sync_count == exp_sync)
            else
            begin
                $display("ERROR %s: sync symbols expected %0d actual %0d",
                         test_name[5], exp_sync, sync_count);
                errors[5]++;
            end
            for (int i = 0; i < 7; i++)
            begin
                $display("Test %s: %0d checks, %0d errors", test_name[i], checks[i], errors[i]);
                total += errors[i];
            end
            $display("Top level assertions: %0d failed",
                     hdmi_tx_top_inst.hdmi_tx_assertions_inst.fail_count);
            total += hdmi_tx_top_inst.hdmi_tx_assertions_inst.fail_count;
            $display("Total: %0d errors in %0d cycles", total, cycles);
            if (total == 0)
                $display("PASS: all tests");
            else
                $display("FAIL: see errors above");
            $finish;
        end
    end

endmodule

//--- dv/hdmi_tx_assertions.sv
// Top level protocol assertions
module hdmi_tx_assertions
(
    input logic       clk_pixel_x5,
    input logic       rst_n,
    input logic       pixel_strobe,
    input logic       pixel_req,
    input logic [5:0] pixel_x,
    input logic [2:0] pixel_y,
    input logic [1:0] tmds_clock_lane
);
    timeunit 1ns;
    timeprecision 1ps;

    // Count of failed properties
    int fail_count = 0;

    // Strobe is one cycle wide, once per pixel
    strobe_single: assert property (@(posedge clk_pixel_x5) disable iff (!rst_n)
        pixel_strobe |=> !pixel_strobe)
        else
        begin
            fail_count++;
            $error("pixel strobe held for more than one cycle");
        end

    strobe_period: assert property (@(posedge clk_pixel_x5) disable iff (!rst_n)
        pixel_strobe |-> ##5 pixel_strobe)
        else
        begin
            fail_count++;
            $error("pixel strobe not repeating every five cycles");
        end

    // Request only inside the active window
    req_window: assert property (@(posedge clk_pixel_x5) disable iff (!rst_n)
        pixel_req |-> (pixel_x < 6'd32) && (pixel_y < 3'd4))
        else
        begin
            fail_count++;
            $error("pixel request outside the active window");
        end

    // Pixel position holds between strobes
    position_stable: assert property (@(posedge clk_pixel_x5) disable iff (!rst_n)
        !pixel_strobe |=> $stable(pixel_x) && $stable(pixel_y))
        else
        begin
            fail_count++;
            $error("pixel position changed without a strobe");
        end

    // Clock word starts right after each load
    clock_word_start: assert property (@(posedge clk_pixel_x5) disable iff (!rst_n)
        pixel_strobe |=> (tmds_clock_lane == 2'b11))
        else
        begin
            fail_count++;
            $error("clock lane did not start its word after a load");
        end

endmodule

//--- dv/tb_clock_gen.sv
// Testbench clock and reset
module tb_clock_gen
(
    output logic clk_pixel_x5,
    output logic rst_n
);
    timeunit 1ns;
    timeprecision 1ps;

    initial
    begin
        clk_pixel_x5 = 1'b0;
        forever
            #4 clk_pixel_x5 = ~clk_pixel_x5;
    end

    // Held for three cycles, released away from the rising edge
    initial
    begin
        rst_n = 1'b0;
        repeat (3) @(posedge clk_pixel_x5);
        @(negedge clk_pixel_x5);
        rst_n = 1'b1;
    end

endmodule

//--- src/hdmi_tx_top.sv
// HDMI transmit top level
module hdmi_tx_top
(
    input  logic        clk_pixel_x5,
    input  logic        rst_n,
    input  logic [23:0] rgb,
    output logic        pixel_req,
    output logic [5:0]  pixel_x,
    output logic [2:0]  pixel_y,
    output logic [1:0]  tmds_lane0,
    output logic [1:0]  tmds_lane1,
    output logic [1:0]  tmds_lane2,
    output logic [1:0]  tmds_clock_lane
);
    import hdmi_pkg::*;

    logic         pixel_strobe;
    logic         hsync;
    logic         vsync;
    tmds_symbol_t symbol [3];

    tmds_if video ();

    video_timing video_timing_inst
    (
        .clk_pixel_x5 (clk_pixel_x5),
        .rst_n        (rst_n),
        .pixel_strobe (pixel_strobe),
        .h_count      (pixel_x),
        .v_count      (pixel_y),
        .hsync        (hsync),
        .vsync        (vsync),
        .active       (pixel_req)
    );

    period_fsm period_fsm_inst
    (
        .clk_pixel_x5 (clk_pixel_x5),
        .rst_n        (rst_n),
        .pixel_strobe (pixel_strobe),
        .h_count      (pixel_x),
        .v_count      (pixel_y),
        .hsync        (hsync),
        .vsync        (vsync),
        .active       (pixel_req),
        .rgb          (rgb),
        .video        (video.source)
    );

    // Channel 0 blue, 1 green, 2 red
    for (genvar i = 0; i < 3; i++)
    begin : gen_encoder
        tmds_encoder tmds_encoder_inst
        (
            .clk_pixel_x5 (clk_pixel_x5),
            .rst_n        (rst_n),
            .video        (video.sink),
            .channel      (2'(i)),
            .symbol       (symbol[i])
        );
    end

    tmds_serializer tmds_serializer_inst
    (
        .clk_pixel_x5    (clk_pixel_x5),
        .rst_n           (rst_n),
        .pixel_strobe    (pixel_strobe),
        .symbol0         (symbol[0]),
        .symbol1         (symbol[1]),
        .symbol2         (symbol[2]),
        .tmds_lane0      (tmds_lane0),
        .tmds_lane1      (tmds_lane1),
        .tmds_lane2      (tmds_lane2),
        .tmds_clock_lane (tmds_clock_lane)
    );

endmodule

//--- serializer/tmds_serializer.sv
// TMDS serializer, two bits per cycle
module tmds_serializer
(
    input  logic                   clk_pixel_x5,
    input  logic                   rst_n,
    input  logic                   pixel_strobe,
    input  hdmi_pkg::tmds_symbol_t symbol0,
    input  hdmi_pkg::tmds_symbol_t symbol1,
    input  hdmi_pkg::tmds_symbol_t symbol2,
    output logic [1:0]             tmds_lane0,
    output logic [1:0]             tmds_lane1,
    output logic [1:0]             tmds_lane2,
    output logic [1:0]             tmds_clock_lane
);
    import hdmi_pkg::*;

    tmds_symbol_t load_value [4];
    tmds_symbol_t word       [4];
    tmds_symbol_t shift      [4];
    logic [1:0]   lane       [4];

    assign load_value[0] = symbol0;
    assign load_value[1] = symbol1;
    assign load_value[2] = symbol2;
    assign load_value[3] = TMDS_CLOCK_PATTERN;

    // Fresh word on the strobe, bits 1:0 go out at once
    always_comb
    begin
        for (int i = 0; i < 4; i++)
            word[i] = pixel_strobe ? load_value[i] : shift[i];
    end

    always_ff @(posedge clk_pixel_x5 or negedge rst_n)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i < 4; i++)
            begin
                shift[i] <= '0;
                lane[i]  <= '0;
            end
        end
        else
        begin
            for (int i = 0; i < 4; i++)
            begin
                shift[i] <= word[i] >> 2;
                lane[i]  <= word[i][1:0];
            end
        end
    end

    assign tmds_lane0      = lane[0];
    assign tmds_lane1      = lane[1];
    assign tmds_lane2      = lane[2];
    assign tmds_clock_lane = lane[3];

endmodule

//--- tmds_encoder/tmds_encoder.sv
// TMDS channel encoder
module tmds_encoder
(
    input  logic                   clk_pixel_x5,
    input  logic                   rst_n,
    tmds_if.sink                   video,
    input  logic [1:0]             channel,
    output hdmi_pkg::tmds_symbol_t symbol
);
    import hdmi_pkg::*;

    logic [7:0]        data;
    logic [1:0]        ctrl;
    logic [3:0]        data_ones;
    logic              use_xnor;
    logic [8:0]        q_m;
    logic [8:0]        q_m_q;
    logic [1:0]        ctrl_q;
    period_t           period_q;
    logic [3:0]        qm_ones;
    logic signed [5:0] balance;
    logic signed [5:0] disparity;
    logic signed [5:0] disparity_next;
    tmds_symbol_t      symbol_next;

    function automatic logic [3:0] ones8(input logic [7:0] value);
        logic [3:0] total;
        total = '0;
        for (int i = 0; i < 8; i++)
            total = total + 4'(value[i]);
        return total;
    endfunction

    // Byte and control pair for this lane
    always_comb
    begin
        case (channel)
            2'd1:
            begin
                data = video.rgb[15:8];
                ctrl = (video.period == PREAMBLE) ? 2'b01 : 2'b00;
            end
            2'd2:
            begin
                data = video.rgb[23:16];
                ctrl = 2'b00;
            end
            default:
            begin
                data = video.rgb[7:0];
                ctrl = {video.vsync, video.hsync};
            end
        endcase
    end

    // Transition minimization
    always_comb
    begin
        data_ones = ones8(data);
        use_xnor  = (data_ones > 4'd4) || ((data_ones == 4'd4) && !data[0]);
        q_m[0]    = data[0];
        for (int i = 1; i < 8; i++)
            q_m[i] = use_xnor ? ~(q_m[i-1] ^ data[i]) : (q_m[i-1] ^ data[i]);
        q_m[8]    = ~use_xnor;
    end

    always_ff @(posedge clk_pixel_x5)
    begin
        if (video.pixel_strobe)
        begin
            q_m_q  <= q_m;
            ctrl_q <= ctrl;
        end
    end

    // DC balancing, balance is ones minus zeros
    always_comb
    begin
        qm_ones = ones8(q_m_q[7:0]);
        balance = $signed({2'b00, qm_ones}) * 6'sd2 - 6'sd8;
        if ((disparity == 6'sd0) || (balance == 6'sd0))
        begin
            symbol_next    = {~q_m_q[8], q_m_q[8], q_m_q[8] ? q_m_q[7:0] : ~q_m_q[7:0]};
            disparity_next = q_m_q[8] ? disparity + balance : disparity - balance;
        end
        else if (((disparity > 6'sd0) && (balance > 6'sd0)) ||
                 ((disparity < 6'sd0) && (balance < 6'sd0)))
        begin
            symbol_next    = {1'b1, q_m_q[8], ~q_m_q[7:0]};
            disparity_next = disparity + (q_m_q[8] ? 6'sd2 : 6'sd0) - balance;
        end
        else
        begin
            symbol_next    = {1'b0, q_m_q[8], q_m_q[7:0]};
            disparity_next = disparity - (q_m_q[8] ? 6'sd0 : 6'sd2) + balance;
        end

        if (period_q == GUARD)
        begin
            symbol_next    = (channel == 2'd1) ? GUARD_WORD_C1 : GUARD_WORD_C02;
            disparity_next = 6'sd0;
        end
        else if (period_q != VIDEO)
        begin
            symbol_next    = CTRL_SYMBOLS[ctrl_q];
            disparity_next = 6'sd0;
        end
    end

    always_ff @(posedge clk_pixel_x5 or negedge rst_n)
    begin
        if (!rst_n)
        begin
            period_q  <= CONTROL;
            disparity <= 6'sd0;
            symbol    <= '0;
        end
        else if (video.pixel_strobe)
        begin
            period_q  <= video.period;
            disparity <= disparity_next;
            symbol    <= symbol_next;
        end
    end

endmodule

//--- src/period_fsm.sv
// Period state machine
`include "hdmi_config.svh"

module period_fsm
(
    input  logic        clk_pixel_x5,
    input  logic        rst_n,
    input  logic        pixel_strobe,
    input  logic [5:0]  h_count,
    input  logic [2:0]  v_count,
    input  logic        hsync,
    input  logic        vsync,
    input  logic        active,
    input  logic [23:0] rgb,
    tmds_if.source      video
);
    import hdmi_pkg::*;

    localparam int PREAMBLE_START = `HDMI_H_TOTAL - `HDMI_PREAMBLE_LEN - `HDMI_GUARD_LEN;

    period_t    state;
    period_t    state_next;
    logic [2:0] count;
    logic [2:0] count_next;
    logic       next_line_active;
    logic       strobe_q;

    // Line 0 is always active
    assign next_line_active = (v_count == 3'(`HDMI_V_TOTAL - 1)) ||
                              ((v_count + 3'd1) < 3'(`HDMI_V_ACTIVE));

    always_comb
    begin
        state_next = state;
        count_next = count + 3'd1;
        case (state)
            CONTROL:
            begin
                count_next = '0;
                if ((h_count == 6'(PREAMBLE_START)) && next_line_active)
                    state_next = PREAMBLE;
            end
            PREAMBLE:
            begin
                if (count == 3'(`HDMI_PREAMBLE_LEN - 1))
                begin
                    state_next = GUARD;
                    count_next = '0;
                end
            end
            GUARD:
            begin
                if (count == 3'(`HDMI_GUARD_LEN - 1))
                    state_next = VIDEO;
            end
            default:
            begin
                // Active window over
                if (!active)
                    state_next = CONTROL;
            end
        endcase
    end

    always_ff @(posedge clk_pixel_x5 or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state       <= CONTROL;
            count       <= '0;
            strobe_q    <= 1'b0;
            video.hsync <= ~`HDMI_SYNC_POLARITY;
            video.vsync <= ~`HDMI_SYNC_POLARITY;
        end
        else
        begin
            strobe_q <= pixel_strobe;
            if (pixel_strobe)
            begin
                state       <= state_next;
                count       <= count_next;
                video.hsync <= hsync;
                video.vsync <= vsync;
            end
        end
    end

    always_ff @(posedge clk_pixel_x5)
    begin
        if (pixel_strobe)
            video.rgb <= rgb;
    end

    assign video.period       = state;
    assign video.pixel_strobe = strobe_q;

endmodule

//--- src/video_timing.sv
// Raster timing generator
`include "hdmi_config.svh"

module video_timing
(
    input  logic       clk_pixel_x5,
    input  logic       rst_n,
    output logic       pixel_strobe,
    output logic [5:0] h_count,
    output logic [2:0] v_count,
    output logic       hsync,
    output logic       vsync,
    output logic       active
);

    localparam int H_SYNC_START = `HDMI_H_ACTIVE + `HDMI_H_FRONT;
    localparam int V_SYNC_START = `HDMI_V_ACTIVE + `HDMI_V_FRONT;

    logic [2:0] phase;
    logic [5:0] h_next;
    logic [2:0] v_next;
    logic       h_sync_window;
    logic       v_sync_window;

    always_ff @(posedge clk_pixel_x5 or negedge rst_n)
    begin
        if (!rst_n)
            phase <= '0;
        else if (pixel_strobe)
            phase <= '0;
        else
            phase <= phase + 3'd1;
    end

    // Last phase of each pixel
    assign pixel_strobe = (phase == 3'(`HDMI_PIXEL_PHASES - 1));

    always_comb
    begin
        h_next = h_count + 6'd1;
        v_next = v_count;
        if (h_count == 6'(`HDMI_H_TOTAL - 1))
        begin
            h_next = '0;
            if (v_count == 3'(`HDMI_V_TOTAL - 1))
                v_next = '0;
            else
                v_next = v_count + 3'd1;
        end
        h_sync_window = (h_next >= 6'(H_SYNC_START)) &&
                        (h_next < 6'(H_SYNC_START + `HDMI_H_SYNC));
        v_sync_window = (v_next >= 3'(V_SYNC_START)) &&
                        (v_next < 3'(V_SYNC_START + `HDMI_V_SYNC));
    end

    // Outputs follow the counters they describe
    always_ff @(posedge clk_pixel_x5 or negedge rst_n)
    begin
        if (!rst_n)
        begin
            h_count <= '0;
            v_count <= '0;
            active  <= 1'b0;
            hsync   <= ~`HDMI_SYNC_POLARITY;
            vsync   <= ~`HDMI_SYNC_POLARITY;
        end
        else if (pixel_strobe)
        begin
            h_count <= h_next;
            v_count <= v_next;
            active  <= (h_next < 6'(`HDMI_H_ACTIVE)) && (v_next < 3'(`HDMI_V_ACTIVE));
            hsync   <= h_sync_window ? `HDMI_SYNC_POLARITY : ~`HDMI_SYNC_POLARITY;
            vsync   <= v_sync_window ? `HDMI_SYNC_POLARITY : ~`HDMI_SYNC_POLARITY;
        end
    end

endmodule

//--- common/tmds_if.sv
// Pixel stream to the TMDS encoders
interface tmds_if;
    import hdmi_pkg::*;

    logic        pixel_strobe;
    period_t     period;
    logic        hsync;
    logic        vsync;
    logic [23:0] rgb;

    modport source
    (
        output pixel_strobe,
        output period,
        output hsync,
        output vsync,
        output rgb
    );

    modport sink
    (
        input pixel_strobe,
        input period,
        input hsync,
        input vsync,
        input rgb
    );

endinterface

//--- common/hdmi_pkg.sv
// HDMI transmit types
package hdmi_pkg;

    // Period kinds, also the period FSM state
    typedef enum logic [1:0]
    {
        CONTROL  = 2'd0,
        PREAMBLE = 2'd1,
        GUARD    = 2'd2,
        VIDEO    = 2'd3
    } period_t;

    // One 10-bit TMDS character
    typedef logic [9:0] tmds_symbol_t;

    // Clock lane word, sent LSB first
    localparam tmds_symbol_t TMDS_CLOCK_PATTERN = 10'b0000011111;

    // Control characters indexed by {c1, c0}
    localparam logic [3:0][9:0] CTRL_SYMBOLS =
    {
        10'b1010101011,
        10'b0101010100,
        10'b0010101011,
        10'b1101010100
    };

    // Video guard band characters
    localparam tmds_symbol_t GUARD_WORD_C02 = 10'b1011001100;
    localparam tmds_symbol_t GUARD_WORD_C1  = 10'b0100110011;

endpackage

//--- common/hdmi_config.svh
// Raster timing configuration
`ifndef HDMI_CONFIG_SVH
`define HDMI_CONFIG_SVH

// Horizontal, in pixels
`define HDMI_H_ACTIVE      32
`define HDMI_H_FRONT       4
`define HDMI_H_SYNC        6
`define HDMI_H_BACK        12
`define HDMI_H_TOTAL       (`HDMI_H_ACTIVE + `HDMI_H_FRONT + `HDMI_H_SYNC + `HDMI_H_BACK)

// Vertical, in lines
`define HDMI_V_ACTIVE      4
`define HDMI_V_FRONT       1
`define HDMI_V_SYNC        1
`define HDMI_V_BACK        1
`define HDMI_V_TOTAL       (`HDMI_V_ACTIVE + `HDMI_V_FRONT + `HDMI_V_SYNC + `HDMI_V_BACK)

// Preamble and guard band sit inside the back porch
`define HDMI_PREAMBLE_LEN  8
`define HDMI_GUARD_LEN     2

// Fast clock cycles per pixel
`define HDMI_PIXEL_PHASES  5

// Sync level while in the sync pulse
`define HDMI_SYNC_POLARITY 1'b1

`endif
